//--- Makefile
# Verilator build and run of the dual-clock FIFO testbench.

VERILATOR ?= verilator
TOP       ?= tb_async_fifo
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
source/fifo_pkg.sv
source/dual_port_ram.sv
source/ptr_sync.sv
source/wr_ptr_ctrl.sv
source/rd_ptr_ctrl.sv
source/async_fifo.sv
testbench/tb_async_fifo.sv

//--- source/async_fifo.sv
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH   = 8,
  parameter int ADDR_WIDTH   = 4,
  parameter int AFULL_LEVEL  = (1 << ADDR_WIDTH) - 2,
  parameter int AEMPTY_LEVEL = 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output fifo_pkg::wr_flags_t   wr_flags,
  output fifo_pkg::rd_flags_t   rd_flags
);

  logic                  ram_we;
  logic [ADDR_WIDTH-1:0] ram_waddr;
  logic                  ram_re;
  logic [ADDR_WIDTH-1:0] ram_raddr;
  logic [ADDR_WIDTH:0]   wr_gray;
  logic [ADDR_WIDTH:0]   wr_gray_sync; // write pointer seen in rd_clk.
  logic [ADDR_WIDTH:0]   rd_gray;
  logic [ADDR_WIDTH:0]   rd_gray_sync; // read pointer seen in wr_clk.

  // ####################################################################
  // storage
  // ####################################################################

  dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_ram (
    .wr_clk (wr_clk),
    .we     (ram_we),
    .waddr  (ram_waddr),
    .wdata  (wr_data),
    .rd_clk (rd_clk),
    .re     (ram_re),
    .raddr  (ram_raddr),
    .rdata  (rd_data)
  );

  // ####################################################################
  // write domain
  // ####################################################################

  wr_ptr_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .AFULL_LEVEL (AFULL_LEVEL)
  ) i_wr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .ram_we       (ram_we),
    .ram_waddr    (ram_waddr),
    .wr_gray      (wr_gray),
    .flags        (wr_flags)
  );

  ptr_sync #(
    .WIDTH (ADDR_WIDTH + 1)
  ) i_rd_sync (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  // ####################################################################
  // read domain
  // ####################################################################

  rd_ptr_ctrl #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) i_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .ram_re       (ram_re),
    .ram_raddr    (ram_raddr),
    .rd_gray      (rd_gray),
    .flags        (rd_flags)
  );

  ptr_sync #(
    .WIDTH (ADDR_WIDTH + 1)
  ) i_wr_sync (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

endmodule

//--- source/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  rd_clk,
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [DATA_WIDTH-1:0] rdata
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

  // ####################################################################
  // write port, wr_clk domain
  // ####################################################################

  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ####################################################################
  // read port, rd_clk domain
  // ####################################################################

  // the controllers never let both ports touch one address in the same
  // window: a written slot is only read once the write pointer passed it.
  always_ff @(posedge rd_clk) begin
    if (re) begin
      rdata <= mem[raddr]; // holds between accepted reads.
    end
  end

endmodule

//--- source/fifo_pkg.sv
package fifo_pkg;

  // ####################################################################
  // status flag groups
  // ####################################################################

  typedef struct packed {
    logic full;   // no room for another word.
    logic afull;  // fill count at or above the almost-full level.
  } wr_flags_t;

  typedef struct packed {
    logic empty;  // nothing to read.
    logic aempty; // fill count at or below the almost-empty level.
  } rd_flags_t;

  localparam wr_flags_t WR_FLAGS_RST = '{full: 1'b0, afull: 1'b0};
  localparam rd_flags_t RD_FLAGS_RST = '{empty: 1'b1, aempty: 1'b1};

  // ####################################################################
  // parameter limits and pointer coding
  // ####################################################################

  localparam int MIN_ADDR_WIDTH = 2;  // depth 4.
  localparam int MAX_ADDR_WIDTH = 30; // pointer must fit the 32-bit helpers.

  function automatic logic [31:0] bin2gray(input logic [31:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [31:0] gray2bin(input logic [31:0] gray);
    logic [31:0] bin;
    bin[31] = gray[31];
    for (int i = 30; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // running xor from the msb down.
    end
    return bin;
  endfunction

endpackage

//--- source/ptr_sync.sv
`timescale 1ns/1ps

module ptr_sync #(
  parameter int WIDTH = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] gray_in,
  output logic [WIDTH-1:0] gray_out
);

  localparam logic [WIDTH-1:0] MAX_STEP = WIDTH'(1) << (WIDTH - 1);

  logic [WIDTH-1:0] meta;
  logic [WIDTH-1:0] bin_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta     <= '0;
      gray_out <= '0;
    end else begin
      meta     <= gray_in;  // may go metastable.
      gray_out <= meta;
    end
  end

  assign bin_in = WIDTH'(fifo_pkg::gray2bin(32'(gray_in)));

  // the source pointer only counts forward, and never by more than the depth
  // between two sampling edges. a broken gray stream decodes to a jump
  // backward or far ahead, so this catches bad coding on the crossing.
  a_gray_step : assert property (@(posedge clk) disable iff (!rst_n)
      WIDTH'(bin_in - $past(bin_in)) <= MAX_STEP)
    else $error("ptr_sync: gray pointer jumped backward or past the depth.");

endmodule

//--- source/rd_ptr_ctrl.sv
`timescale 1ns/1ps

module rd_ptr_ctrl #(
  parameter int ADDR_WIDTH   = 4,
  parameter int AEMPTY_LEVEL = 2
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_gray_sync,
  output logic                  ram_re,
  output logic [ADDR_WIDTH-1:0] ram_raddr,
  output logic [ADDR_WIDTH:0]   rd_gray,
  output fifo_pkg::rd_flags_t   flags
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [PTR_W-1:0] AEMPTY_THR = PTR_W'(AEMPTY_LEVEL);

  logic [PTR_W-1:0]    rd_bin;
  logic [PTR_W-1:0]    rd_bin_nxt;
  logic [PTR_W-1:0]    rd_gray_nxt;
  logic [PTR_W-1:0]    wr_bin_sync;
  logic [PTR_W-1:0]    fill_nxt;
  fifo_pkg::rd_flags_t flags_nxt;

  // ####################################################################
  // pointers
  // ####################################################################

  assign ram_re      = rd_en && !flags.empty;
  assign ram_raddr   = rd_bin[ADDR_WIDTH-1:0];
  assign rd_bin_nxt  = rd_bin + PTR_W'(ram_re);
  assign rd_gray_nxt = PTR_W'(fifo_pkg::bin2gray(32'(rd_bin_nxt)));
  assign wr_bin_sync = PTR_W'(fifo_pkg::gray2bin(32'(wr_gray_sync)));

  // ####################################################################
  // flags
  // ####################################################################

  assign fill_nxt = wr_bin_sync - rd_bin_nxt; // may understate, never over.

  always_comb begin
    flags_nxt.empty  = (fill_nxt == '0);
    flags_nxt.aempty = (fill_nxt <= AEMPTY_THR);
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      flags   <= fifo_pkg::RD_FLAGS_RST;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      flags   <= flags_nxt;
    end
  end

  // ####################################################################
  // checks
  // ####################################################################

  if (ADDR_WIDTH < fifo_pkg::MIN_ADDR_WIDTH ||
      ADDR_WIDTH > fifo_pkg::MAX_ADDR_WIDTH) begin : g_bad_addr_width
    $error("rd_ptr_ctrl: ADDR_WIDTH %0d out of range.", ADDR_WIDTH);
  end

  if (AEMPTY_LEVEL < 0 || AEMPTY_LEVEL >= (1 << ADDR_WIDTH)) begin : g_bad_aempty
    $error("rd_ptr_ctrl: AEMPTY_LEVEL %0d out of range.", AEMPTY_LEVEL);
  end

  // the synchronized write pointer only moves forward, so meeting it now
  // means empty was already raised on the previous edge.
  a_no_read_empty : assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      ram_re |-> (wr_bin_sync - rd_bin) != '0)
    else $error("rd_ptr_ctrl: read accepted with the FIFO empty.");

endmodule

//--- source/wr_ptr_ctrl.sv
`timescale 1ns/1ps

module wr_ptr_ctrl #(
  parameter int ADDR_WIDTH  = 4,
  parameter int AFULL_LEVEL = (1 << ADDR_WIDTH) - 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH:0]   rd_gray_sync,
  output logic                  ram_we,
  output logic [ADDR_WIDTH-1:0] ram_waddr,
  output logic [ADDR_WIDTH:0]   wr_gray,
  output fifo_pkg::wr_flags_t   flags
);

  localparam int PTR_W = ADDR_WIDTH + 1;
  localparam logic [PTR_W-1:0] DEPTH     = PTR_W'(1 << ADDR_WIDTH);
  localparam logic [PTR_W-1:0] AFULL_THR = PTR_W'(AFULL_LEVEL);

  logic [PTR_W-1:0]    wr_bin;
  logic [PTR_W-1:0]    wr_bin_nxt;
  logic [PTR_W-1:0]    wr_gray_nxt;
  logic [PTR_W-1:0]    rd_bin_sync;
  logic [PTR_W-1:0]    fill_nxt;
  fifo_pkg::wr_flags_t flags_nxt;

  // ####################################################################
  // pointers
  // ####################################################################

  assign ram_we      = wr_en && !flags.full;
  assign ram_waddr   = wr_bin[ADDR_WIDTH-1:0];
  assign wr_bin_nxt  = wr_bin + PTR_W'(ram_we);
  assign wr_gray_nxt = PTR_W'(fifo_pkg::bin2gray(32'(wr_bin_nxt)));
  assign rd_bin_sync = PTR_W'(fifo_pkg::gray2bin(32'(rd_gray_sync)));

  // ####################################################################
  // flags
  // ####################################################################

  assign fill_nxt = wr_bin_nxt - rd_bin_sync; // may overstate, never under.

  always_comb begin
    flags_nxt.full  = (fill_nxt == DEPTH);
    flags_nxt.afull = (fill_nxt >= AFULL_THR);
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      flags   <= fifo_pkg::WR_FLAGS_RST;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt; // registered, so the crossing sees clean edges.
      flags   <= flags_nxt;
    end
  end

  // ####################################################################
  // checks
  // ####################################################################

  if (ADDR_WIDTH < fifo_pkg::MIN_ADDR_WIDTH ||
      ADDR_WIDTH > fifo_pkg::MAX_ADDR_WIDTH) begin : g_bad_addr_width
    $error("wr_ptr_ctrl: ADDR_WIDTH %0d out of range.", ADDR_WIDTH);
  end

  if (AFULL_LEVEL < 1 || AFULL_LEVEL > (1 << ADDR_WIDTH)) begin : g_bad_afull
    $error("wr_ptr_ctrl: AFULL_LEVEL %0d out of range.", AFULL_LEVEL);
  end

  // the synchronized read pointer only moves forward, so a gap of the full
  // depth now means full was already raised on the previous edge.
  a_no_write_full : assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      ram_we |-> (wr_bin - rd_bin_sync) != DEPTH)
    else $error("wr_ptr_ctrl: write accepted with the FIFO full.");

endmodule

//--- testbench/tb_async_fifo.sv
`timescale 1ns/1ps

module tb_async_fifo;

  localparam int DATA_WIDTH   = 8;
  localparam int ADDR_WIDTH   = 4;
  localparam int DEPTH        = 1 << ADDR_WIDTH;
  localparam int AFULL_LEVEL  = DEPTH - 2;
  localparam int AEMPTY_LEVEL = 2;

  localparam int RD_PERIOD = 100;
  localparam int WR_PERIOD = 70;
  localparam int WR_OFFSET = 17;  // keeps the two clocks' edges apart.

  localparam int RESET_CYCLES = 4;
  localparam int WRITE_HEAVY  = 60;
  localparam int READ_HEAVY   = 60;
  localparam int BALANCED     = 120;
  localparam int IDLE_CYCLES  = 8;  // one to stop the strobes, then the flags settle.
  localparam int ROUNDS       = 4;
  localparam int TOTAL_CYCLES = RESET_CYCLES +
                                ROUNDS * (WRITE_HEAVY + READ_HEAVY + BALANCED + 3 * IDLE_CYCLES);
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 50) * RD_PERIOD;

  localparam logic [31:0] SEED = 32'h80563487;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  fifo_pkg::wr_flags_t   wr_flags;
  fifo_pkg::rd_flags_t   rd_flags;

  logic [DATA_WIDTH-1:0] model_q [$];  // words in the FIFO, oldest first.
  int unsigned           wr_pct = 0;   // write strobe chance per wr_clk cycle, percent.
  int unsigned           rd_pct = 0;
  int unsigned           wr_blocked = 0;
  int unsigned           rd_blocked = 0;
  int unsigned           rd_count = 0;

  async_fifo i_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .wr_flags (wr_flags),
    .rd_flags (rd_flags)
  );

  // ####################################################################
  // clocks
  // ####################################################################

  initial begin : rd_clock
    rd_clk = 1'b0;
    forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  end

  initial begin : wr_clock
    wr_clk = 1'b0;
    #(WR_OFFSET);
    forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  end

  // ####################################################################
  // reporting
  // ####################################################################

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error.");
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // ####################################################################
  // phases
  // ####################################################################

  task automatic run_phase(input int unsigned wr_chance, input int unsigned rd_chance,
                           input int cycles);
    wr_pct = wr_chance;
    rd_pct = rd_chance;
    repeat (cycles) @(posedge rd_clk);
  endtask

  // with both strobes idle the flags have caught up and must match the model.
  task automatic settle_and_check(input string name);
    int fill;
    wr_pct = 0;
    rd_pct = 0;
    repeat (IDLE_CYCLES) @(posedge rd_clk);
    #5;
    fill = model_q.size();
    compare_values({name, ": full"}, 32'(fill == DEPTH), 32'(wr_flags.full));
    compare_values({name, ": afull"}, 32'(fill >= AFULL_LEVEL), 32'(wr_flags.afull));
    compare_values({name, ": empty"}, 32'(fill == 0), 32'(rd_flags.empty));
    compare_values({name, ": aempty"}, 32'(fill <= AEMPTY_LEVEL), 32'(rd_flags.aempty));
  endtask

  // ####################################################################
  // write side
  // ####################################################################

  initial begin : write_driver
    bit wr_pend;
    wr_pend = 1'b0;
    wr_en   = 1'b0;
    wr_data = '0;
    wait (wr_rst_n === 1'b1);
    forever begin
      @(posedge wr_clk);
      if (wr_pend) begin
        if (model_q.size() >= DEPTH) begin
          abort_run("overflow: a write was accepted while the FIFO held its full depth.");
        end else begin
          model_q.push_back(wr_data);
        end
      end
      #1;
      wr_en   = ($urandom_range(99) < wr_pct);
      wr_data = DATA_WIDTH'($urandom);
      wr_pend = wr_en && !wr_flags.full;  // full only moves at wr_clk edges.
      if (wr_en && wr_flags.full) begin
        wr_blocked++;
      end
    end
  end

  // ####################################################################
  // read side
  // ####################################################################

  initial begin : read_driver
    bit                    rd_pend;
    bit                    have_word;
    logic [DATA_WIDTH-1:0] last_word;
    rd_pend   = 1'b0;
    have_word = 1'b0;
    last_word = '0;
    rd_en     = 1'b0;
    wait (rd_rst_n === 1'b1);
    forever begin
      @(posedge rd_clk);
      if (rd_pend) begin
        if (model_q.size() == 0) begin
          abort_run("underflow: a read was accepted while the FIFO was empty.");
        end else begin
          last_word = model_q.pop_front();
          have_word = 1'b1;
          rd_count++;
        end
      end
      #1;
      if (have_word) begin
        compare_values("read data", 32'(last_word), 32'(rd_data));  // also checks the hold.
      end
      rd_en   = ($urandom_range(99) < rd_pct);
      rd_pend = rd_en && !rd_flags.empty;
      if (rd_en && rd_flags.empty) begin
        rd_blocked++;
      end
    end
  end

  // ####################################################################
  // main sequence
  // ####################################################################

  initial begin : main
    void'($urandom(SEED));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge rd_clk);
    #1;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    compare_values("reset: full", 32'(1'b0), 32'(wr_flags.full));
    compare_values("reset: afull", 32'(1'b0), 32'(wr_flags.afull));
    compare_values("reset: empty", 32'(1'b1), 32'(rd_flags.empty));
    compare_values("reset: aempty", 32'(1'b1), 32'(rd_flags.aempty));

    for (int r = 0; r < ROUNDS; r++) begin
      run_phase(100, 15, WRITE_HEAVY);  // fills up and keeps pushing.
      settle_and_check("after write burst");
      run_phase(15, 100, READ_HEAVY);   // drains and keeps pulling.
      settle_and_check("after read burst");
      run_phase(50, 50, BALANCED);
      settle_and_check("after balanced traffic");
    end

    compare_values("writes held off while full", 32'(1'b1), 32'(wr_blocked > 0));
    compare_values("reads held off while empty", 32'(1'b1), 32'(rd_blocked > 0));
    compare_values("words read", 32'(1'b1), 32'(rd_count > 0));
    $display("TEST OK");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("timeout: the run did not finish within the expected time.");
  end

endmodule
